/* Makefile */
VERILATOR  ?= verilator
TOP        := l2_tag_lookup_tb
RTL_TOP    := l2_tag_lookup
FILELIST   := l2_tag_lookup.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall -Wno-fatal
RUN_FLAGS  := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/l2_tag_lookup_chk.sv */
`timescale 1ns/10ps
`include "l2_tag_config.svh"

module l2_tag_lookup_chk (
    input logic                   clk_i,
    input logic                   arst_n_i,
    input logic                   req_i,
    input logic                   resp_valid_i,
    input logic                   hit_i,
    input logic                   stg_valid_i,
    input logic                   tag_we_i,
    input logic                   tag_wvalid_i,
    input logic [`L2_INDEX_W-1:0] stg_index_i,
    input logic [`L2_TAG_W-1:0]   stg_tag_i
);

    int fail_count = 0;

    // fixed two-cycle latency with no lost or spurious responses
    latency_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        resp_valid_i == $past(req_i, 2))
        else begin
            $error("response not two cycles after its request");
            fail_count++;
        end

    // array writes only in the stage cycle that follows a request strobe
    write_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tag_we_i |-> $past(req_i))
        else begin
            $error("tag write without a request in the stage");
            fail_count++;
        end

    // same index and tag right after an invalidate hit must miss
    inval_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (stg_valid_i && $past(tag_we_i && !tag_wvalid_i)
            && stg_index_i == $past(stg_index_i) && stg_tag_i == $past(stg_tag_i))
        |=> !hit_i)
        else begin
            $error("hit on an entry just invalidated");
            fail_count++;
        end

endmodule

bind l2_tag_lookup l2_tag_lookup_chk l2_tag_lookup_chk_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (req_i),
    .resp_valid_i (resp_valid_o),
    .hit_i        (hit_o),
    .stg_valid_i  (stg_valid),
    .tag_we_i     (tag_we),
    .tag_wvalid_i (tag_wvalid),
    .stg_index_i  (stg_index),
    .stg_tag_i    (stg_tag)
);

/* dv/l2_tag_lookup_tb.sv */
`timescale 1ns/10ps
`include "l2_tag_config.svh"

module l2_tag_lookup_tb
    import l2_tag_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int RAND_REQS  = 300;
    localparam int TBL_MAX    = 40;
    localparam int LINE_W     = `L2_ADDR_W - `L2_OFFSET_W;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  req_i;
    l2_op_e                op_i;
    logic [`L2_ADDR_W-1:0] addr_i;
    logic                  resp_valid_o;
    logic                  hit_o;
    logic [`L2_WAY_W-1:0]  way_o;
    logic                  full_o;
    logic [LINE_W-1:0]     miss_line_o;

    // directed table, one row per request
    l2_op_e                tbl_op   [TBL_MAX];
    logic [`L2_ADDR_W-1:0] tbl_addr [TBL_MAX];
    logic                  tbl_hit  [TBL_MAX];
    logic [`L2_WAY_W-1:0]  tbl_way  [TBL_MAX];
    logic                  tbl_full [TBL_MAX];
    int                    n_rows = 0;

    // reference model of valid bits, tags and the victim pointer
    logic                 m_valid [`L2_SETS][`L2_WAYS];
    logic [`L2_TAG_W-1:0] m_tag   [`L2_SETS][`L2_WAYS];
    logic [`L2_WAY_W-1:0] m_ptr;

    // pending responses packed as {op, hit, way, full, line}
    logic [LINE_W+6:0] exp_q [$];
    logic [15:0]       lfsr_q = 16'd10909;
    int                err_count = 0;
    int                n_resp = 0;

    l2_tag_lookup l2_tag_lookup_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .resp_valid_o (resp_valid_o),
        .hit_o        (hit_o),
        .way_o        (way_o),
        .full_o       (full_o),
        .miss_line_o  (miss_line_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // tag above index above byte offset
    function automatic logic [`L2_ADDR_W-1:0] make_addr(input int tag, input int idx,
                                                        input int off);
        return {tag[`L2_TAG_W-1:0], idx[`L2_INDEX_W-1:0], off[`L2_OFFSET_W-1:0]};
    endfunction

    task automatic add_row(input l2_op_e op, input logic [`L2_ADDR_W-1:0] addr,
                           input logic hit, input int way, input logic full);
        tbl_op[n_rows]   = op;
        tbl_addr[n_rows] = addr;
        tbl_hit[n_rows]  = hit;
        tbl_way[n_rows]  = way[`L2_WAY_W-1:0];
        tbl_full[n_rows] = full;
        n_rows++;
    endtask

    task automatic build_table();
        // empty array, plain lookups miss
        add_row(L2_OP_LOOKUP, make_addr('h1234, 3, 'h15), 0, 0, 0);
        add_row(L2_OP_LOOKUP, make_addr('hbeef, 'h3ff, 'h3f), 0, 0, 0);
        // fill set 5 in pointer order, then hit every way with the set full
        for (int w = 0; w < 8; w++) begin
            add_row(L2_OP_ALLOC, make_addr('h100 + w, 5, 0), 0, w, 0);
        end
        for (int w = 0; w < 8; w++) begin
            add_row(L2_OP_LOOKUP, make_addr('h100 + w, 5, 0), 1, w, 1);
        end
        // pointer has wrapped to way 0, evicting tag 100
        add_row(L2_OP_ALLOC, make_addr('h200, 5, 0), 0, 0, 1);
        add_row(L2_OP_LOOKUP, make_addr('h100, 5, 0), 0, 0, 1);
        add_row(L2_OP_LOOKUP, make_addr('h200, 5, 'h08), 1, 0, 1);
        // invalidate hit clears way 3, a miss leaves everything alone
        add_row(L2_OP_INVAL, make_addr('h103, 5, 0), 1, 3, 1);
        add_row(L2_OP_LOOKUP, make_addr('h103, 5, 0), 0, 0, 0);
        add_row(L2_OP_INVAL, make_addr('h999, 5, 0), 0, 0, 0);
        add_row(L2_OP_LOOKUP, make_addr('h104, 5, 0), 1, 4, 0);
        // victim follows the pointer even with way 3 free
        add_row(L2_OP_ALLOC, make_addr('h300, 5, 0), 0, 1, 0);
        add_row(L2_OP_LOOKUP, make_addr('h300, 5, 0), 1, 1, 0);
        add_row(L2_OP_LOOKUP, make_addr('h101, 5, 0), 0, 0, 0);
        // allocate that hits does not move the pointer
        add_row(L2_OP_ALLOC, make_addr('h300, 5, 0), 1, 1, 0);
        add_row(L2_OP_ALLOC, make_addr('h400, 6, 0), 0, 2, 0);
        add_row(L2_OP_LOOKUP, make_addr('h400, 6, 'h10), 1, 2, 0);
    endtask

    // predict one response, then apply its effect on the model
    task automatic model_apply(input l2_op_e op, input logic [`L2_ADDR_W-1:0] addr,
                               output logic hit, output logic [`L2_WAY_W-1:0] way,
                               output logic full);
        int                   idx;
        logic [`L2_TAG_W-1:0] tag;
        idx  = int'(addr[`L2_OFFSET_W +: `L2_INDEX_W]);
        tag  = addr[`L2_ADDR_W-1 -: `L2_TAG_W];
        hit  = 1'b0;
        way  = m_ptr;
        full = 1'b1;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = w[`L2_WAY_W-1:0];
            end
            if (!m_valid[idx][w]) begin
                full = 1'b0;
            end
        end
        if (op == L2_OP_ALLOC && !hit) begin
            m_valid[idx][m_ptr] = 1'b1;
            m_tag[idx][m_ptr]   = tag;
            m_ptr               = m_ptr + 1'b1;
        end else if (op == L2_OP_INVAL && hit) begin
            m_valid[idx][way] = 1'b0;
        end
    endtask

    task automatic issue_request(input l2_op_e op, input logic [`L2_ADDR_W-1:0] addr,
                                 input logic hit, input logic [`L2_WAY_W-1:0] way,
                                 input logic full);
        @(posedge clk_i);
        #1;
        req_i  = 1'b1;
        op_i   = op;
        addr_i = addr;
        // expected line is the byte address with the offset dropped
        exp_q.push_back({op, hit, way, full, addr[`L2_ADDR_W-1:`L2_OFFSET_W]});
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    task automatic check_response();
        logic [LINE_W+6:0] e;
        l2_op_e            e_op;
        if (exp_q.size() == 0) begin
            $display("ERROR: response at %0t with no request outstanding", $time);
            err_count++;
            return;
        end
        e    = exp_q.pop_front();
        e_op = l2_op_e'(e[LINE_W+6:LINE_W+5]);
        n_resp++;
        check_val("hit_o", 32'(hit_o), 32'(e[LINE_W+4]));
        check_val("full_o", 32'(full_o), 32'(e[LINE_W]));
        // way only defined for a hit or an allocate fill
        if (e[LINE_W+4] || e_op == L2_OP_ALLOC) begin
            check_val("way_o", 32'(way_o), 32'(e[LINE_W+3:LINE_W+1]));
        end
        if (!e[LINE_W+4]) begin
            check_val("miss_line_o", 32'(miss_line_o), 32'(e[LINE_W-1:0]));
        end
    endtask

    // outputs settle after the rising edge, sample mid-cycle
    initial begin
        forever begin
            @(negedge clk_i);
            if (arst_n_i === 1'b1 && resp_valid_o === 1'b1) begin
                check_response();
            end
        end
    end

    // table is built at time zero, so its length is known after 1 ns
    initial begin
        #1;
        #((n_rows + RAND_REQS + 20) * CLK_PERIOD);
        $display("timeout: responses did not all arrive within the expected run time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0]           r_op;
        logic [31:0]           r_set;
        logic [31:0]           r_tag;
        logic [31:0]           r_off;
        l2_op_e                op;
        logic [`L2_ADDR_W-1:0] addr;
        logic                  e_hit;
        logic [`L2_WAY_W-1:0]  e_way;
        logic                  e_full;
        int                    chk_fails;
        arst_n_i = 1'b0;
        req_i    = 1'b0;
        op_i     = L2_OP_LOOKUP;
        addr_i   = '0;
        m_ptr    = '0;
        for (int s = 0; s < `L2_SETS; s++) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end
        build_table();
        repeat (2) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        // directed rows back to back, model kept in step
        for (int i = 0; i < n_rows; i++) begin
            model_apply(tbl_op[i], tbl_addr[i], e_hit, e_way, e_full);
            issue_request(tbl_op[i], tbl_addr[i], tbl_hit[i], tbl_way[i], tbl_full[i]);
        end
        // random phase over sets 4 to 7 and 16 tags, mostly allocates
        for (int i = 0; i < RAND_REQS; i++) begin
            draw_bits(3, r_op);
            draw_bits(2, r_set);
            draw_bits(4, r_tag);
            draw_bits(6, r_off);
            if (r_op < 5) begin
                op = L2_OP_ALLOC;
            end else if (r_op < 7) begin
                op = L2_OP_LOOKUP;
            end else begin
                op = L2_OP_INVAL;
            end
            addr = make_addr('h100 + int'(r_tag), 4 + int'(r_set), int'(r_off));
            model_apply(op, addr, e_hit, e_way, e_full);
            issue_request(op, addr, e_hit, e_way, e_full);
        end
        @(posedge clk_i);
        #1;
        req_i = 1'b0;
        // drain, bounded by the watchdog
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (2) @(negedge clk_i);
        chk_fails = l2_tag_lookup_inst.l2_tag_lookup_chk_inst.fail_count;
        $display("responses %0d, mismatches %0d, assertion failures %0d",
                 n_resp, err_count, chk_fails);
        if (err_count == 0 && chk_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* l2_tag_lookup.f */
+incdir+source
source/l2_tag_pkg.sv
source/l2_req_stage.sv
source/l2_cache_tag.sv
source/l2_fill_ctrl.sv
source/l2_tag_lookup.sv
dv/l2_tag_lookup_chk.sv
dv/l2_tag_lookup_tb.sv

/* source/l2_cache_tag.sv */
`timescale 1ns/10ps
`include "l2_tag_config.svh"

module l2_cache_tag (
    input  logic                   clk_i,
    input  logic [`L2_INDEX_W-1:0] index_i,
    input  logic [`L2_TAG_W-1:0]   tag_i,
    input  logic                   we_i,
    input  logic                   wvalid_i,
    input  logic [`L2_WAY_W-1:0]   way_i,
    output logic                   hit_o,
    output logic [`L2_WAY_W-1:0]   way_o,
    output logic                   full_o
);

    // one valid bit per way, packed per set
    logic [`L2_WAYS-1:0] valid_mem [`L2_SETS];

    // tag per set and way
    logic [`L2_TAG_W-1:0] tag_mem [`L2_SETS][`L2_WAYS];

    // valid bits and tags of the addressed set
    logic [`L2_WAYS-1:0] set_valid;
    logic [`L2_WAYS-1:0] hit_vec;
    logic [`L2_WAY_W-1:0] hit_way;
    logic full_q;

    // memory starts empty, there is no reset on the array
    initial begin
        for (int s = 0; s < `L2_SETS; s++) begin
            valid_mem[s] = '0;
        end
    end

    assign set_valid = valid_mem[index_i];

    // compare against every way, qualified with valid
    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            hit_vec[w] = set_valid[w] && (tag_mem[index_i][w] == tag_i);
        end
    end

    // priority encoder, lowest way wins if ever more than one matches
    // on a miss the requested way is passed through
    always_comb begin
        hit_way = way_i;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                hit_way = `L2_WAY_W'(w);
            end
        end
    end

    assign hit_o = |hit_vec;
    assign way_o = hit_way;

    // all-valid flag sampled before this cycle's write lands
    always_ff @(posedge clk_i) begin
        full_q <= &set_valid;
    end

    assign full_o = full_q;

    // write into the hit way, or the supplied way on a miss
    // takes effect at the end of the stage cycle
    always @(posedge clk_i) begin
        if (we_i) begin
            tag_mem[index_i][hit_way]   <= tag_i;
            valid_mem[index_i][hit_way] <= wvalid_i;
        end
    end

endmodule

/* source/l2_fill_ctrl.sv */
`timescale 1ns/10ps
`include "l2_tag_config.svh"

module l2_fill_ctrl
    import l2_tag_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                stg_valid_i,
    input  l2_op_e                              stg_op_i,
    input  logic [`L2_ADDR_W-`L2_OFFSET_W-1:0] stg_line_i,
    input  logic                                lookup_hit_i,
    input  logic [`L2_WAY_W-1:0]                lookup_way_i,
    input  logic                                set_full_i,
    output logic                                tag_we_o,
    output logic                                tag_wvalid_o,
    output logic [`L2_WAY_W-1:0]                victim_way_o,
    output logic                                resp_valid_o,
    output logic                                hit_o,
    output logic [`L2_WAY_W-1:0]                way_o,
    output logic                                full_o,
    output logic [`L2_ADDR_W-`L2_OFFSET_W-1:0] miss_line_o
);

    logic alloc_fill;
    logic inval_hit;
    logic [`L2_WAY_W-1:0] victim_q;

    // response registers
    logic resp_valid_q;
    logic hit_q;
    logic [`L2_WAY_W-1:0] way_q;
    logic [`L2_ADDR_W-`L2_OFFSET_W-1:0] line_q;

    // allocate that misses installs the tag
    assign alloc_fill = stg_valid_i && (stg_op_i == L2_OP_ALLOC) && !lookup_hit_i;
    // invalidate only acts when it hits
    assign inval_hit  = stg_valid_i && (stg_op_i == L2_OP_INVAL) && lookup_hit_i;

    assign tag_we_o     = alloc_fill || inval_hit;
    assign tag_wvalid_o = alloc_fill;
    assign victim_way_o = victim_q;

    // round-robin pointer, wraps after the last way
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            victim_q <= '0;
        end else if (alloc_fill) begin
            victim_q <= victim_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= stg_valid_i;
        end
    end

    // lookup_way_i already carries the victim pointer when nothing hits
    always_ff @(posedge clk_i) begin
        if (stg_valid_i) begin
            hit_q  <= lookup_hit_i;
            way_q  <= lookup_way_i;
            line_q <= stg_line_i;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign hit_o        = hit_q;
    assign way_o        = way_q;
    assign miss_line_o  = line_q;

    // full flag is registered in the tag memory on the same edge
    assign full_o = set_full_i;

endmodule

/* source/l2_req_stage.sv */
`timescale 1ns/10ps
`include "l2_tag_config.svh"

module l2_req_stage
    import l2_tag_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                req_i,
    input  l2_op_e                              op_i,
    input  logic [`L2_ADDR_W-1:0]               addr_i,
    output logic                                stg_valid_o,
    output l2_op_e                              stg_op_o,
    output logic [`L2_INDEX_W-1:0]              stg_index_o,
    output logic [`L2_TAG_W-1:0]                stg_tag_o,
    output logic [`L2_ADDR_W-`L2_OFFSET_W-1:0] stg_line_o
);

    // captured request word and operation
    l2_addr_u addr_q;
    l2_op_e   op_q;
    logic     valid_q;

    // valid lasts exactly one cycle per strobe
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i;
        end
    end

    // payload only loads on a strobe
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            addr_q <= addr_i;
            op_q   <= op_i;
        end
    end

    assign stg_valid_o = valid_q;
    assign stg_op_o    = op_q;

    // field view drives the tag memory
    assign stg_index_o = addr_q.fld.index;
    assign stg_tag_o   = addr_q.fld.tag;

    // line view goes to the fill controller for miss reporting
    assign stg_line_o  = addr_q.ln.line;

endmodule

/* source/l2_tag_config.svh */
`ifndef L2_TAG_CONFIG_SVH
`define L2_TAG_CONFIG_SVH

// byte address of a request
`define L2_ADDR_W 32

// 64-byte lines
`define L2_OFFSET_W 6

// set index and number of sets, kept in step
`define L2_INDEX_W 10
`define L2_SETS 1024

// tag is whatever is left above index and offset
`define L2_TAG_W 16

// associativity is fixed at 8, the way number follows from it
`define L2_WAYS 8
`define L2_WAY_W 3

`endif

/* source/l2_tag_lookup.sv */
`timescale 1ns/10ps
`include "l2_tag_config.svh"

module l2_tag_lookup
    import l2_tag_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                req_i,
    input  l2_op_e                              op_i,
    input  logic [`L2_ADDR_W-1:0]               addr_i,
    output logic                                resp_valid_o,
    output logic                                hit_o,
    output logic [`L2_WAY_W-1:0]                way_o,
    output logic                                full_o,
    output logic [`L2_ADDR_W-`L2_OFFSET_W-1:0] miss_line_o
);

    // request stage outputs
    logic                                stg_valid;
    l2_op_e                              stg_op;
    logic [`L2_INDEX_W-1:0]              stg_index;
    logic [`L2_TAG_W-1:0]                stg_tag;
    logic [`L2_ADDR_W-`L2_OFFSET_W-1:0] stg_line;

    // tag memory results
    logic                 lookup_hit;
    logic [`L2_WAY_W-1:0] lookup_way;
    logic                 set_full;

    // write controls back into the tag memory
    logic                 tag_we;
    logic                 tag_wvalid;
    logic [`L2_WAY_W-1:0] victim_way;

    l2_req_stage l2_req_stage_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .stg_valid_o (stg_valid),
        .stg_op_o    (stg_op),
        .stg_index_o (stg_index),
        .stg_tag_o   (stg_tag),
        .stg_line_o  (stg_line)
    );

    l2_cache_tag l2_cache_tag_inst (
        .clk_i    (clk_i),
        .index_i  (stg_index),
        .tag_i    (stg_tag),
        .we_i     (tag_we),
        .wvalid_i (tag_wvalid),
        .way_i    (victim_way),
        .hit_o    (lookup_hit),
        .way_o    (lookup_way),
        .full_o   (set_full)
    );

    l2_fill_ctrl l2_fill_ctrl_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .stg_valid_i  (stg_valid),
        .stg_op_i     (stg_op),
        .stg_line_i   (stg_line),
        .lookup_hit_i (lookup_hit),
        .lookup_way_i (lookup_way),
        .set_full_i   (set_full),
        .tag_we_o     (tag_we),
        .tag_wvalid_o (tag_wvalid),
        .victim_way_o (victim_way),
        .resp_valid_o (resp_valid_o),
        .hit_o        (hit_o),
        .way_o        (way_o),
        .full_o       (full_o),
        .miss_line_o  (miss_line_o)
    );

endmodule

/* source/l2_tag_pkg.sv */
`include "l2_tag_config.svh"

package l2_tag_pkg;

    // one address word, two ways to look at it
    typedef union packed {
        // lookup view
        struct packed {
            logic [`L2_TAG_W-1:0]    tag;
            logic [`L2_INDEX_W-1:0]  index;
            logic [`L2_OFFSET_W-1:0] offset;
        } fld;
        // line view, used when reporting a miss
        struct packed {
            logic [`L2_ADDR_W-`L2_OFFSET_W-1:0] line;
            logic [`L2_OFFSET_W-1:0]            offset;
        } ln;
    } l2_addr_u;

    // request operation
    typedef enum logic [1:0] {
        L2_OP_LOOKUP = 2'd0,
        L2_OP_ALLOC  = 2'd1,
        L2_OP_INVAL  = 2'd2
    } l2_op_e;

endpackage
